// File: Makefile
TB_TOP := tb_soc_ctrl

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -Wall -f verilog.f --top-module soc_ctrl_top

sim:
	verilator --binary --timing -j 0 -f verilog.f --top-module $(TB_TOP) -o sim_$(TB_TOP)
	./obj_dir/sim_$(TB_TOP) | tee sim.log
	grep -q '^\*\* PASS \*\*$$' sim.log

clean:
	rm -rf obj_dir sim.log

// File: activity_dimmer.sv
// ==========================================================
// Activity light: one lit cycle per event, then a dark
// hold-off window that sets the perceived brightness.
// ==========================================================
`timescale 1ns/10ps
`default_nettype none

module activity_dimmer (
	 input  logic clk100mhz_i
	,input  logic rst_p
	,input  logic act_evt_i
	,output logic act_o
);

	logic [soc_ctrl_pkg::ACT_CNTR_BITSZ-1:0] dim_cntr;

	always_ff @(posedge clk100mhz_i) begin
		if (rst_p) begin
			act_o    <= 1'b0;
			dim_cntr <= '0;
		end else if (dim_cntr != '0) begin
			// Events inside the window are dropped.
			act_o    <= 1'b0;
			dim_cntr <= dim_cntr - 1'b1;
		end else if (act_evt_i) begin
			act_o    <= 1'b1;
			dim_cntr <= soc_ctrl_pkg::ACT_DIM_CYCLES;
		end else begin
			act_o <= 1'b0;
		end
	end

	a_single_lit: assert property (
		@(posedge clk100mhz_i) disable iff (rst_p)
		act_o |=> !act_o
	);

endmodule

`default_nettype wire

// File: rst_sequencer.sv
// ==========================================================
// Reset sequencer: holds the system in reset for a fixed
// count, re-arms on warm reset and latches power off.
// ==========================================================
`timescale 1ns/10ps
`default_nettype none

module rst_sequencer (
	 input  logic clk100mhz_i
	,input  logic rst_p
	,input  logic warm_req_i
	,input  logic off_req_i
	,output logic sys_rst_o
	,output logic pwr_off_o
);

	logic [soc_ctrl_pkg::RST_CNTR_BITSZ-1:0] rst_cntr;
	logic                                    pwr_off_q;
	logic                                    sys_rst_q;
	logic                                    reload;

	// Any active reset source keeps the counter at its full value.
	assign reload = rst_p || warm_req_i || off_req_i || pwr_off_q;

	always_ff @(posedge clk100mhz_i) begin
		if (reload) begin
			rst_cntr <= soc_ctrl_pkg::RST_HOLD_CYCLES;
		end else if (rst_cntr != '0) begin
			rst_cntr <= rst_cntr - 1'b1;
		end
	end

	// Power off sticks until the external reset is pressed again.
	always_ff @(posedge clk100mhz_i) begin
		if (rst_p) begin
			pwr_off_q <= 1'b0;
		end else if (off_req_i) begin
			pwr_off_q <= 1'b1;
		end
	end

	// Registered so that the release lands a full hold count
	// after the first edge with every source gone.
	always_ff @(posedge clk100mhz_i) begin
		if (rst_p) begin
			sys_rst_q <= 1'b1;
		end else begin
			sys_rst_q <= reload || (rst_cntr != '0);
		end
	end

	assign sys_rst_o = sys_rst_q;
	assign pwr_off_o = pwr_off_q;

	// A powered-off system never leaves reset.
	a_off_holds_rst: assert property (
		@(posedge clk100mhz_i) disable iff (rst_p)
		pwr_off_o |-> sys_rst_o
	);

endmodule

`default_nettype wire

// File: soc_ctrl_pkg.sv
// ==========================================================
// System control package: bus widths, register map, reset
// and dimming constants, and the device table contents.
// ==========================================================
`default_nettype none

package soc_ctrl_pkg;

	// Bus widths.
	localparam int ARCH_BITSZ     = 32;
	localparam int AXI_ADDR_BITSZ = 8;

	// Device table, one entry per bus slot.
	localparam int DEV_COUNT = 8;

	// Slot order is sdcard, devtbl, gpio, dma, intctrl, uart, ram, invalid.
	localparam logic [15:0] DEV_ID_TBL [0:DEV_COUNT-1] = '{
		16'd4, 16'd7, 16'd6, 16'd2, 16'd3, 16'd5, 16'd1, 16'd0
	};

	localparam logic DEV_USEINTR_TBL [0:DEV_COUNT-1] = '{
		1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0
	};

	// Map sizes in bytes; the ram slot spans 32MB.
	localparam logic [ARCH_BITSZ-1:0] DEV_MAPSZ_TBL [0:DEV_COUNT-1] = '{
		32'h40, 32'h20, 32'h40, 32'h40,
		32'h40, 32'h40, 32'h2000000, 32'h400
	};

	// Register map.
	localparam logic [AXI_ADDR_BITSZ-1:0] REG_RSTCTRL     = 8'h00;
	localparam logic [AXI_ADDR_BITSZ-1:0] REG_DEVTBL_BASE = 8'h40;
	localparam int                        REG_DEVTBL_STRIDE = 8;

	// Reset hold length after the last reset source goes away.
	localparam int                        RST_CNTR_BITSZ  = 7;
	localparam logic [RST_CNTR_BITSZ-1:0] RST_HOLD_CYCLES = 7'd64;

	// Dark window that follows each lit cycle of the activity light.
	localparam int                        ACT_CNTR_BITSZ = 7;
	localparam logic [ACT_CNTR_BITSZ-1:0] ACT_DIM_CYCLES = 7'd127;

	// AXI response codes.
	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

// File: soc_ctrl_top.sv
// ==========================================================
// System control block: register file, reset sequencer and
// activity light.
// ==========================================================
`timescale 1ns/10ps
`default_nettype none

module soc_ctrl_top (
	 input  logic                                    clk100mhz_i
	,input  logic                                    rst_p
	,input  logic                                    s_awvalid_i
	,output logic                                    s_awready_o
	,input  logic [soc_ctrl_pkg::AXI_ADDR_BITSZ-1:0] s_awaddr_i
	,input  logic                                    s_wvalid_i
	,output logic                                    s_wready_o
	,input  logic [soc_ctrl_pkg::ARCH_BITSZ-1:0]     s_wdata_i
	,input  logic [soc_ctrl_pkg::ARCH_BITSZ/8-1:0]   s_wstrb_i
	,output logic                                    s_bvalid_o
	,input  logic                                    s_bready_i
	,output logic [1:0]                              s_bresp_o
	,input  logic                                    s_arvalid_i
	,output logic                                    s_arready_o
	,input  logic [soc_ctrl_pkg::AXI_ADDR_BITSZ-1:0] s_araddr_i
	,output logic                                    s_rvalid_o
	,input  logic                                    s_rready_i
	,output logic [soc_ctrl_pkg::ARCH_BITSZ-1:0]     s_rdata_o
	,output logic [1:0]                              s_rresp_o
	,input  logic                                    act_evt_i
	,output logic                                    sys_rst_o
	,output logic                                    pwr_off_o
	,output logic                                    act_o
);

	logic warm_req;
	logic off_req;
	logic sys_rst;

	sysctl_regs u_regs (
		 .clk100mhz_i (clk100mhz_i)
		,.rst_p       (rst_p)
		,.s_awvalid_i (s_awvalid_i)
		,.s_awready_o (s_awready_o)
		,.s_awaddr_i  (s_awaddr_i)
		,.s_wvalid_i  (s_wvalid_i)
		,.s_wready_o  (s_wready_o)
		,.s_wdata_i   (s_wdata_i)
		,.s_wstrb_i   (s_wstrb_i)
		,.s_bvalid_o  (s_bvalid_o)
		,.s_bready_i  (s_bready_i)
		,.s_bresp_o   (s_bresp_o)
		,.s_arvalid_i (s_arvalid_i)
		,.s_arready_o (s_arready_o)
		,.s_araddr_i  (s_araddr_i)
		,.s_rvalid_o  (s_rvalid_o)
		,.s_rready_i  (s_rready_i)
		,.s_rdata_o   (s_rdata_o)
		,.s_rresp_o   (s_rresp_o)
		,.sys_rst_i   (sys_rst)
		,.warm_req_o  (warm_req)
		,.off_req_o   (off_req)
	);

	rst_sequencer u_rst (
		 .clk100mhz_i (clk100mhz_i)
		,.rst_p       (rst_p)
		,.warm_req_i  (warm_req)
		,.off_req_i   (off_req)
		,.sys_rst_o   (sys_rst)
		,.pwr_off_o   (pwr_off_o)
	);

	activity_dimmer u_act (
		 .clk100mhz_i (clk100mhz_i)
		,.rst_p       (rst_p)
		,.act_evt_i   (act_evt_i)
		,.act_o       (act_o)
	);

	assign sys_rst_o = sys_rst;

endmodule

`default_nettype wire

// File: sysctl_regs.sv
// ==========================================================
// System control registers on AXI4-Lite: reset control word
// and read-only device table.
// ==========================================================
`timescale 1ns/10ps
`default_nettype none

module sysctl_regs (
	 input  logic                                      clk100mhz_i
	,input  logic                                      rst_p
	,input  logic                                      s_awvalid_i
	,output logic                                      s_awready_o
	,input  logic [soc_ctrl_pkg::AXI_ADDR_BITSZ-1:0]   s_awaddr_i
	,input  logic                                      s_wvalid_i
	,output logic                                      s_wready_o
	,input  logic [soc_ctrl_pkg::ARCH_BITSZ-1:0]       s_wdata_i
	,input  logic [soc_ctrl_pkg::ARCH_BITSZ/8-1:0]     s_wstrb_i
	,output logic                                      s_bvalid_o
	,input  logic                                      s_bready_i
	,output logic [1:0]                                s_bresp_o
	,input  logic                                      s_arvalid_i
	,output logic                                      s_arready_o
	,input  logic [soc_ctrl_pkg::AXI_ADDR_BITSZ-1:0]   s_araddr_i
	,output logic                                      s_rvalid_o
	,input  logic                                      s_rready_i
	,output logic [soc_ctrl_pkg::ARCH_BITSZ-1:0]       s_rdata_o
	,output logic [1:0]                                s_rresp_o
	,input  logic                                      sys_rst_i
	,output logic                                      warm_req_o
	,output logic                                      off_req_o
);

	logic                                           wr_accept;
	logic                                           wr_hit;
	logic                                           bvalid_q;
	logic [1:0]                                     bresp_q;
	logic                                           rd_accept;
	logic                                           rvalid_q;
	logic [soc_ctrl_pkg::ARCH_BITSZ-1:0]            rdata_q;
	logic [soc_ctrl_pkg::ARCH_BITSZ-1:0]            rd_data;
	logic [soc_ctrl_pkg::AXI_ADDR_BITSZ-1:0]        rd_off;
	logic [$clog2(soc_ctrl_pkg::DEV_COUNT)-1:0]     rd_slot;
	logic                                           rd_in_tbl;
	logic                                           rd_is_ctrl;
	logic [1:0]                                     rst_ctrl_q;

	// Address and data are taken together, one write in flight.
	assign wr_accept   = s_awvalid_i && s_wvalid_i && !bvalid_q;
	assign s_awready_o = wr_accept;
	assign s_wready_o  = wr_accept;

	assign wr_hit = (s_awaddr_i[soc_ctrl_pkg::AXI_ADDR_BITSZ-1:2] ==
		soc_ctrl_pkg::REG_RSTCTRL[soc_ctrl_pkg::AXI_ADDR_BITSZ-1:2]);

	always_ff @(posedge clk100mhz_i) begin
		if (rst_p) begin
			bvalid_q <= 1'b0;
		end else if (wr_accept) begin
			bvalid_q <= 1'b1;
		end else if (s_bready_i) begin
			bvalid_q <= 1'b0;
		end
	end

	// Only the reset control word is writable.
	always_ff @(posedge clk100mhz_i) begin
		if (wr_accept) begin
			bresp_q <= wr_hit ? soc_ctrl_pkg::RESP_OKAY : soc_ctrl_pkg::RESP_SLVERR;
		end
	end

	assign s_bvalid_o = bvalid_q;
	assign s_bresp_o  = bresp_q;

	// Bits 1:0 are rst1 and rst0. The word self-clears once the
	// sequencer has taken the system into reset.
	always_ff @(posedge clk100mhz_i) begin
		if (rst_p || sys_rst_i) begin
			rst_ctrl_q <= 2'b00;
		end else if (wr_accept && wr_hit && s_wstrb_i[0]) begin
			rst_ctrl_q <= s_wdata_i[1:0];
		end
	end

	// Codes 10 and 11 both restart the hold count, 01 powers off.
	assign warm_req_o = rst_ctrl_q[1];
	assign off_req_o  = rst_ctrl_q[0] && !rst_ctrl_q[1];

	assign rd_accept   = s_arvalid_i && !rvalid_q;
	assign s_arready_o = rd_accept;

	assign rd_is_ctrl = (s_araddr_i[soc_ctrl_pkg::AXI_ADDR_BITSZ-1:2] ==
		soc_ctrl_pkg::REG_RSTCTRL[soc_ctrl_pkg::AXI_ADDR_BITSZ-1:2]);

	assign rd_off    = s_araddr_i - soc_ctrl_pkg::REG_DEVTBL_BASE;
	assign rd_in_tbl = (s_araddr_i >= soc_ctrl_pkg::REG_DEVTBL_BASE) &&
		(rd_off < soc_ctrl_pkg::DEV_COUNT * soc_ctrl_pkg::REG_DEVTBL_STRIDE);
	assign rd_slot   = rd_off[$clog2(soc_ctrl_pkg::REG_DEVTBL_STRIDE) +:
		$clog2(soc_ctrl_pkg::DEV_COUNT)];

	// Unmapped addresses read as zero.
	always_comb begin
		rd_data = '0;
		if (rd_is_ctrl) begin
			rd_data[1:0] = rst_ctrl_q;
		end else if (rd_in_tbl) begin
			if (!rd_off[2]) begin
				rd_data[15:0] = soc_ctrl_pkg::DEV_ID_TBL[rd_slot];
				rd_data[16]   = soc_ctrl_pkg::DEV_USEINTR_TBL[rd_slot];
			end else begin
				// Second word of a slot holds the map size.
				rd_data = soc_ctrl_pkg::DEV_MAPSZ_TBL[rd_slot];
			end
		end
	end

	always_ff @(posedge clk100mhz_i) begin
		if (rst_p) begin
			rvalid_q <= 1'b0;
		end else if (rd_accept) begin
			rvalid_q <= 1'b1;
		end else if (s_rready_i) begin
			rvalid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk100mhz_i) begin
		if (rd_accept) begin
			rdata_q <= rd_data;
		end
	end

	assign s_rvalid_o = rvalid_q;
	assign s_rdata_o  = rdata_q;
	assign s_rresp_o  = soc_ctrl_pkg::RESP_OKAY;

	a_bvalid_hold: assert property (
		@(posedge clk100mhz_i) disable iff (rst_p)
		s_bvalid_o && !s_bready_i |=> s_bvalid_o
	);

	a_rdata_hold: assert property (
		@(posedge clk100mhz_i) disable iff (rst_p)
		s_rvalid_o && !s_rready_i |=> s_rvalid_o && $stable(s_rdata_o)
	);

endmodule

`default_nettype wire

// File: tb_checker.sv
// ==========================================================
// Testbench checker: cycle model of the reset sequencer,
// register map, AXI4-Lite responses and activity light.
// ==========================================================
`timescale 1ns/10ps
`default_nettype none

module tb_checker (
	 input  logic                                    clk100mhz_i
	,input  logic                                    rst_p
	,input  logic                                    s_awvalid_i
	,input  logic                                    s_awready_o
	,input  logic [soc_ctrl_pkg::AXI_ADDR_BITSZ-1:0] s_awaddr_i
	,input  logic                                    s_wvalid_i
	,input  logic                                    s_wready_o
	,input  logic [soc_ctrl_pkg::ARCH_BITSZ-1:0]     s_wdata_i
	,input  logic [soc_ctrl_pkg::ARCH_BITSZ/8-1:0]   s_wstrb_i
	,input  logic                                    s_bvalid_o
	,input  logic                                    s_bready_i
	,input  logic [1:0]                              s_bresp_o
	,input  logic                                    s_arvalid_i
	,input  logic                                    s_arready_o
	,input  logic [soc_ctrl_pkg::AXI_ADDR_BITSZ-1:0] s_araddr_i
	,input  logic                                    s_rvalid_o
	,input  logic                                    s_rready_i
	,input  logic [soc_ctrl_pkg::ARCH_BITSZ-1:0]     s_rdata_o
	,input  logic [1:0]                              s_rresp_o
	,input  logic                                    act_evt_i
	,input  logic                                    sys_rst_o
	,input  logic                                    pwr_off_o
	,input  logic                                    act_o
	,input  int                                      test_id_i
	,output int                                      err_cnt_o
	,output int                                      chk_cnt_o
);

	logic                                      model_ok = 1'b0;
	logic [1:0]                                m_ctrl;
	logic                                      m_off;
	logic [soc_ctrl_pkg::RST_CNTR_BITSZ-1:0]   m_cnt;
	logic                                      m_sys_rst;
	logic                                      m_bvalid;
	logic [1:0]                                m_bresp;
	logic                                      m_rvalid;
	logic [soc_ctrl_pkg::ARCH_BITSZ-1:0]       m_rdata;
	logic                                      m_act;
	logic [soc_ctrl_pkg::ACT_CNTR_BITSZ-1:0]   m_dim;
	logic                                      wr_acc;
	logic                                      rd_acc;
	logic                                      wr_ctrl;
	logic                                      hold_src;
	int unsigned                               cyc = 0;
	int unsigned                               warm_at = 0;
	logic                                      warm_armed = 1'b0;
	logic                                      sys_rst_prev = 1'b0;
	int                                        err_cnt = 0;
	int                                        chk_cnt = 0;

	function automatic string test_label(input int id);
		case (id)
			1: test_label = "reset_release";
			2: test_label = "devtbl_read";
			3: test_label = "warm_reset";
			4: test_label = "power_off";
			5: test_label = "devtbl_write";
			6: test_label = "activity";
			default: test_label = "startup";
		endcase
	endfunction

	// Read data as the register map defines it.
	function automatic logic [31:0] expect_rdata(input logic [7:0] addr, input logic [1:0] ctrl);
		int off;
		int slot;
		expect_rdata = '0;
		off = int'(addr) - int'(soc_ctrl_pkg::REG_DEVTBL_BASE);
		slot = off / soc_ctrl_pkg::REG_DEVTBL_STRIDE;
		if ((addr >> 2) == (soc_ctrl_pkg::REG_RSTCTRL >> 2)) begin
			expect_rdata[1:0] = ctrl;
		end else if (off >= 0 && slot < soc_ctrl_pkg::DEV_COUNT) begin
			if ((off % soc_ctrl_pkg::REG_DEVTBL_STRIDE) < 4) begin
				expect_rdata[15:0] = soc_ctrl_pkg::DEV_ID_TBL[slot];
				expect_rdata[16]   = soc_ctrl_pkg::DEV_USEINTR_TBL[slot];
			end else begin
				expect_rdata = soc_ctrl_pkg::DEV_MAPSZ_TBL[slot];
			end
		end
	endfunction

	task automatic compare_value(input string what, input logic [31:0] exp, input logic [31:0] act);
		chk_cnt++;
		if (act !== exp) begin
			err_cnt++;
			$display("** Error %s: %s expected 0x%0h, actual 0x%0h at %0t",
				test_label(test_id_i), what, exp, act, $time);
		end
	endtask

	task automatic flag_protocol(input string what);
		err_cnt++;
		$display("Protocol error in %s: %s at %0t", test_label(test_id_i), what, $time);
	endtask

	assign wr_acc   = s_awvalid_i && s_wvalid_i && !m_bvalid;
	assign rd_acc   = s_arvalid_i && !m_rvalid;
	assign wr_ctrl  = (s_awaddr_i >> 2) == (soc_ctrl_pkg::REG_RSTCTRL >> 2);
	assign hold_src = rst_p || m_ctrl[1] || (m_ctrl == 2'b01) || m_off;

	// Compare the values held since the last edge, then step the model.
	always @(posedge clk100mhz_i) begin
		if (model_ok) begin
			compare_value("sys_rst_o", 32'(m_sys_rst), 32'(sys_rst_o));
			compare_value("pwr_off_o", 32'(m_off), 32'(pwr_off_o));
			compare_value("act_o", 32'(m_act), 32'(act_o));
			compare_value("s_bvalid_o", 32'(m_bvalid), 32'(s_bvalid_o));
			compare_value("s_rvalid_o", 32'(m_rvalid), 32'(s_rvalid_o));
			if (m_bvalid) begin
				compare_value("s_bresp_o", 32'(m_bresp), 32'(s_bresp_o));
			end
			if (m_rvalid) begin
				compare_value("s_rdata_o", m_rdata, s_rdata_o);
				compare_value("s_rresp_o", 32'(soc_ctrl_pkg::RESP_OKAY), 32'(s_rresp_o));
			end
			if (s_awready_o !== wr_acc) begin
				flag_protocol("write ready does not match the request and pending response");
			end
			if (s_wready_o !== wr_acc) begin
				flag_protocol("write data ready does not match the request and pending response");
			end
			if (s_arready_o !== rd_acc) begin
				flag_protocol("read ready does not match the request and pending response");
			end
		end
		model_ok <= model_ok || rst_p;

		if (rst_p) begin
			m_bvalid <= 1'b0;
			m_rvalid <= 1'b0;
		end else begin
			if (wr_acc) begin
				m_bvalid <= 1'b1;
				m_bresp  <= wr_ctrl ? soc_ctrl_pkg::RESP_OKAY : soc_ctrl_pkg::RESP_SLVERR;
			end else if (s_bready_i) begin
				m_bvalid <= 1'b0;
			end
			if (rd_acc) begin
				m_rvalid <= 1'b1;
				m_rdata  <= expect_rdata(s_araddr_i, m_ctrl);
			end else if (s_rready_i) begin
				m_rvalid <= 1'b0;
			end
		end

		// Control word clears while the system sits in reset.
		if (rst_p || m_sys_rst) begin
			m_ctrl <= 2'b00;
		end else if (wr_acc && wr_ctrl && s_wstrb_i[0]) begin
			m_ctrl <= s_wdata_i[1:0];
		end
		if (rst_p) begin
			m_off <= 1'b0;
		end else if (m_ctrl == 2'b01) begin
			m_off <= 1'b1;
		end
		if (hold_src) begin
			m_cnt <= soc_ctrl_pkg::RST_HOLD_CYCLES;
		end else if (m_cnt != '0) begin
			m_cnt <= m_cnt - 1'b1;
		end
		m_sys_rst <= hold_src || (m_cnt != '0);

		if (rst_p) begin
			m_act <= 1'b0;
			m_dim <= '0;
		end else if (m_dim != '0) begin
			m_act <= 1'b0;
			m_dim <= m_dim - 1'b1;
		end else begin
			m_act <= act_evt_i;
			m_dim <= act_evt_i ? soc_ctrl_pkg::ACT_DIM_CYCLES : '0;
		end
	end

	// Warm reset release window, counted from the write handshake edge.
	always @(posedge clk100mhz_i) begin
		cyc          <= cyc + 1;
		sys_rst_prev <= sys_rst_o;
		if (rst_p) begin
			warm_armed <= 1'b0;
		end else if (wr_acc && wr_ctrl && s_wstrb_i[0] && s_wdata_i[1]) begin
			warm_at    <= cyc;
			warm_armed <= 1'b1;
		end else if (warm_armed && sys_rst_prev && !sys_rst_o) begin
			warm_armed <= 1'b0;
			chk_cnt++;
			if ((cyc - 1 - warm_at) < 64 || (cyc - 1 - warm_at) > 68) begin
				err_cnt++;
				$display("** Error %s: release expected 64 to 68 cycles, actual %0d",
					test_label(test_id_i), cyc - 1 - warm_at);
			end
		end
	end

	assign err_cnt_o = err_cnt;
	assign chk_cnt_o = chk_cnt;

endmodule

`default_nettype wire

// File: tb_clkgen.sv
// ==========================================================
// Testbench clock and reset: 100 MHz clock, reset held for
// the first 8 cycles and again on request.
// ==========================================================
`timescale 1ns/10ps
`default_nettype none

module tb_clkgen (
	 output logic clk100mhz_o
	,output logic rst_p_o
	,input  logic rst_req_i
);

	logic        clk = 1'b0;
	logic        rst_q = 1'b1;
	int unsigned cyc = 0;

	always #5 clk = ~clk;

	// Reset drops after 8 sampled edges; a request re-asserts it.
	always @(posedge clk) begin
		if (cyc < 8) begin
			cyc <= cyc + 1;
		end
		rst_q <= (cyc < 7) || rst_req_i;
	end

	assign clk100mhz_o = clk;
	assign rst_p_o     = rst_q;

endmodule

`default_nettype wire

// File: tb_soc_ctrl.sv
// ==========================================================
// Testbench top for the system control block: AXI4-Lite
// bus tasks and random stimulus.
// ==========================================================
`timescale 1ns/10ps
`default_nettype none

module tb_soc_ctrl;

	// About 40 accesses of ~10 cycles, 3 reset sequences of ~70
	// and a 1200 cycle activity run, with twice the margin.
	localparam int TIMEOUT_CYCLES = 4000;

	logic        clk100mhz_i;
	logic        rst_p;
	logic        rst_req = 1'b0;
	logic        s_awvalid_i;
	logic        s_awready_o;
	logic [7:0]  s_awaddr_i;
	logic        s_wvalid_i;
	logic        s_wready_o;
	logic [31:0] s_wdata_i;
	logic [3:0]  s_wstrb_i;
	logic        s_bvalid_o;
	logic        s_bready_i;
	logic [1:0]  s_bresp_o;
	logic        s_arvalid_i;
	logic        s_arready_o;
	logic [7:0]  s_araddr_i;
	logic        s_rvalid_o;
	logic        s_rready_i;
	logic [31:0] s_rdata_o;
	logic [1:0]  s_rresp_o;
	logic        act_evt_i;
	logic        sys_rst_o;
	logic        pwr_off_o;
	logic        act_o;
	int          test_id = 0;
	int          err_cnt;
	int          chk_cnt;
	int unsigned cyc_cnt = 0;
	logic [7:0]  rd_addrs [0:23];
	logic [7:0]  wr_addrs [0:3];
	logic [7:0]  tmp_addr;
	int          pick;

	tb_clkgen u_clk (
		 .clk100mhz_o (clk100mhz_i)
		,.rst_p_o     (rst_p)
		,.rst_req_i   (rst_req)
	);

	soc_ctrl_top dut (.*);

	tb_checker u_chk (
		 .*
		,.test_id_i (test_id)
		,.err_cnt_o (err_cnt)
		,.chk_cnt_o (chk_cnt)
	);

	task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
		int unsigned delay;
		delay = $urandom_range(0, 3);
		@(posedge clk100mhz_i);
		s_awvalid_i <= 1'b1;
		s_awaddr_i  <= addr;
		s_wvalid_i  <= 1'b1;
		s_wdata_i   <= data;
		s_wstrb_i   <= 4'hf;
		do @(posedge clk100mhz_i); while (!s_awready_o);
		s_awvalid_i <= 1'b0;
		s_wvalid_i  <= 1'b0;
		// Hold off the response for a few cycles.
		repeat (delay) @(posedge clk100mhz_i);
		s_bready_i <= 1'b1;
		do @(posedge clk100mhz_i); while (!(s_bvalid_o && s_bready_i));
		s_bready_i <= 1'b0;
	endtask

	task automatic read_reg(input logic [7:0] addr);
		int unsigned delay;
		delay = $urandom_range(0, 3);
		@(posedge clk100mhz_i);
		s_arvalid_i <= 1'b1;
		s_araddr_i  <= addr;
		do @(posedge clk100mhz_i); while (!s_arready_o);
		s_arvalid_i <= 1'b0;
		repeat (delay) @(posedge clk100mhz_i);
		s_rready_i <= 1'b1;
		do @(posedge clk100mhz_i); while (!(s_rvalid_o && s_rready_i));
		s_rready_i <= 1'b0;
	endtask

	task automatic wait_reset_release();
		while (sys_rst_o !== 1'b1) @(posedge clk100mhz_i);
		while (sys_rst_o !== 1'b0) @(posedge clk100mhz_i);
	endtask

	initial begin
		void'($urandom(91));
		s_awvalid_i = 1'b0;
		s_awaddr_i  = '0;
		s_wvalid_i  = 1'b0;
		s_wdata_i   = '0;
		s_wstrb_i   = '0;
		s_bready_i  = 1'b0;
		s_arvalid_i = 1'b0;
		s_araddr_i  = '0;
		s_rready_i  = 1'b0;
		act_evt_i   = 1'b0;

		test_id <= 1;
		wait_reset_release();

		// All 16 table words plus 8 unmapped words, in shuffled order.
		test_id <= 2;
		for (int i = 0; i < 16; i++) begin
			rd_addrs[i] = 8'(soc_ctrl_pkg::REG_DEVTBL_BASE + 4 * i);
		end
		for (int i = 16; i < 24; i++) begin
			if ($urandom_range(0, 1) == 1) begin
				rd_addrs[i] = 8'(8'h80 + 4 * $urandom_range(0, 31));
			end else begin
				rd_addrs[i] = 8'(4 * $urandom_range(1, 15));
			end
		end
		for (int i = 23; i > 0; i--) begin
			pick           = $urandom_range(0, i);
			tmp_addr       = rd_addrs[i];
			rd_addrs[i]    = rd_addrs[pick];
			rd_addrs[pick] = tmp_addr;
		end
		foreach (rd_addrs[i]) begin
			read_reg(rd_addrs[i]);
		end

		test_id <= 3;
		write_reg(soc_ctrl_pkg::REG_RSTCTRL, 32'h2);
		wait_reset_release();
		write_reg(soc_ctrl_pkg::REG_RSTCTRL, 32'h3);
		wait_reset_release();
		read_reg(soc_ctrl_pkg::REG_RSTCTRL);

		// Power off holds until the external reset is pulsed.
		test_id <= 4;
		write_reg(soc_ctrl_pkg::REG_RSTCTRL, 32'h1);
		while (!pwr_off_o) @(posedge clk100mhz_i);
		repeat ($urandom_range(16, 32)) @(posedge clk100mhz_i);
		rst_req <= 1'b1;
		repeat (2) @(posedge clk100mhz_i);
		rst_req <= 1'b0;
		wait_reset_release();

		test_id <= 5;
		for (int i = 0; i < 4; i++) begin
			wr_addrs[i] = 8'(soc_ctrl_pkg::REG_DEVTBL_BASE + 4 * $urandom_range(0, 15));
			write_reg(wr_addrs[i], $urandom);
		end
		foreach (wr_addrs[i]) begin
			read_reg(wr_addrs[i]);
		end

		test_id <= 6;
		repeat (1200) begin
			@(posedge clk100mhz_i);
			act_evt_i <= ($urandom_range(0, 15) == 0);
		end
		@(posedge clk100mhz_i);
		act_evt_i <= 1'b0;
		repeat (2) @(posedge clk100mhz_i);
		@(negedge clk100mhz_i);

		$display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

	always @(posedge clk100mhz_i) begin
		cyc_cnt <= cyc_cnt + 1;
		if (cyc_cnt == TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("** FAIL **");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: verilog.f
soc_ctrl_pkg.sv
rst_sequencer.sv
activity_dimmer.sv
sysctl_regs.sv
soc_ctrl_top.sv
tb_clkgen.sv
tb_checker.sv
tb_soc_ctrl.sv
